// File: logic/pll_rcfg_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width, channel count and CSR offset constants
// for the PLL reconfiguration front end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef PLL_RCFG_MACROS_SVH
`define PLL_RCFG_MACROS_SVH

// Channel bank size and host address split
`define NUM_CHANNELS      4
`define CHAN_SEL_BITS     2
`define CHAN_ADDR_BITS    10
`define HOST_ADDR_BITS    (`CHAN_SEL_BITS + `CHAN_ADDR_BITS)

// Data widths
`define BUS_DATA_BITS     32
`define XCVR_DATA_BITS    8

// Layout of the 10-bit channel address
// Bit 9 picks the soft CSR, the rest is offset or register index
`define XCVR_ADDR_BITS    9
`define CSR_INDEX_BITS    4
`define CSR_RSVD_BITS     (`XCVR_ADDR_BITS - `CSR_INDEX_BITS)

// Soft CSR register map
`define CSR_STATUS_OFFSET   0
`define CSR_CONTROL_OFFSET  1

`endif

// File: logic/pll_rcfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared bus, channel and status types; import it
// with a wildcard in the module header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "pll_rcfg_macros.svh"

package pll_rcfg_pkg;

  typedef logic [`CHAN_SEL_BITS-1:0] chan_sel_t;

  // Transceiver view of a channel address
  typedef struct packed {
    logic                        csr_sel;
    logic [`XCVR_ADDR_BITS-1:0]  offset;
  } xcvr_addr_t;

  // Soft CSR view of the same address
  typedef struct packed {
    logic                        csr_sel;
    logic [`CSR_RSVD_BITS-1:0]   rsvd;
    logic [`CSR_INDEX_BITS-1:0]  index;
  } csr_addr_t;

  typedef union packed {
    xcvr_addr_t  xcvr;
    csr_addr_t   csr;
  } chan_addr_u;

  typedef struct packed {
    logic                        read;
    logic                        write;
    logic [`HOST_ADDR_BITS-1:0]  address;
    logic [`BUS_DATA_BITS-1:0]   writedata;
  } host_req_t;

  typedef struct packed {
    logic                        read;
    logic                        write;
    chan_addr_u                  addr;
    logic [`XCVR_DATA_BITS-1:0]  writedata;
  } chan_req_t;

  typedef struct packed {
    logic [`XCVR_DATA_BITS-1:0]  readdata;
    logic                        waitrequest;
  } chan_rsp_t;

  // Field order gives the status register layout, powerdown in bit 3
  typedef struct packed {
    logic  powerdown;
    logic  locked;
    logic  cal_busy;
    logic  avmm_busy;
  } pll_status_t;

endpackage

`default_nettype wire

// File: logic/rcfg_splitter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Splits the shared host request into one request
// per channel using the upper address bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "pll_rcfg_macros.svh"

module rcfg_splitter
  import pll_rcfg_pkg::*;
(
  input  host_req_t                         host_req,
  output chan_req_t [`NUM_CHANNELS-1:0]     chan_req,
  output chan_sel_t                         chan_sel
);

  chan_sel_t  sel;

  // Channel select sits above the per-channel address
  assign sel      = host_req.address[`HOST_ADDR_BITS-1 -: `CHAN_SEL_BITS];
  assign chan_sel = sel;

  always_comb begin
    for (int unsigned ch = 0; ch < `NUM_CHANNELS; ch++) begin
      // Strobes only reach the addressed channel
      chan_req[ch].read      = host_req.read  & (sel == chan_sel_t'(ch));
      chan_req[ch].write     = host_req.write & (sel == chan_sel_t'(ch));
      // Address and data are broadcast
      chan_req[ch].addr      = host_req.address[`CHAN_ADDR_BITS-1:0];
      chan_req[ch].writedata = host_req.writedata[`XCVR_DATA_BITS-1:0];
    end
  end

endmodule

`default_nettype wire

// File: logic/pll_soft_csr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-channel soft CSR: status readback and PLL
// powerdown override, two cycles per access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "pll_rcfg_macros.svh"

module pll_soft_csr
  import pll_rcfg_pkg::*;
(
  input  wire logic                        reconfig_clk,
  input  wire logic                        rst_n,

  input  wire logic                        csr_read,
  input  wire logic                        csr_write,
  input  wire logic [`CSR_INDEX_BITS-1:0]  csr_index,
  input  wire logic [`XCVR_DATA_BITS-1:0]  csr_writedata,
  output chan_rsp_t                        csr_rsp,

  input  pll_status_t                      status,
  output logic                             pll_powerdown
);

  localparam logic [`CSR_INDEX_BITS-1:0] STATUS_IDX  = `CSR_STATUS_OFFSET;
  localparam logic [`CSR_INDEX_BITS-1:0] CONTROL_IDX = `CSR_CONTROL_OFFSET;

  logic         csr_access;
  logic         busy_q;
  logic         complete;
  pll_status_t  status_q;
  // Bit 0 override enable, bit 1 override value
  logic [1:0]   ctrl_q;

  assign csr_access = csr_read | csr_write;

  // First cycle waits, second cycle completes
  assign complete = csr_access & busy_q;

  always_ff @(posedge reconfig_clk) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (csr_access && !busy_q) begin
      busy_q <= 1'b1;
    end else begin
      // Cleared on completion or if the strobe goes away
      busy_q <= 1'b0;
    end
  end

  // Status sampled every cycle
  always_ff @(posedge reconfig_clk) begin
    status_q <= status;
  end

  always_ff @(posedge reconfig_clk) begin
    if (!rst_n) begin
      ctrl_q <= 2'b00;
    end else if (complete && csr_write && csr_index == CONTROL_IDX) begin
      ctrl_q <= csr_writedata[1:0];
    end
  end

  always_comb begin
    case (csr_index)
      STATUS_IDX:  csr_rsp.readdata = {{(`XCVR_DATA_BITS-4){1'b0}}, status_q};
      CONTROL_IDX: csr_rsp.readdata = {{(`XCVR_DATA_BITS-2){1'b0}}, ctrl_q};
      default:     csr_rsp.readdata = '0;
    endcase
  end

  assign csr_rsp.waitrequest = ~busy_q;

  // Override wins when enabled, otherwise follow the PLL input
  assign pll_powerdown = ctrl_q[0] ? ctrl_q[1] : status.powerdown;

endmodule

`default_nettype wire

// File: logic/chan_router.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One channel: steers a request to the soft CSR or
// the transceiver port by address bit 9
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "pll_rcfg_macros.svh"

module chan_router
  import pll_rcfg_pkg::*;
(
  input  wire logic                        reconfig_clk,
  input  wire logic                        rst_n,

  // Request from the splitter and response to the host side
  input  chan_req_t                        chan_req,
  output chan_rsp_t                        chan_rsp,

  // PLL status in, powerdown out
  input  pll_status_t                      status,
  output logic                             pll_powerdown,

  // Transceiver port
  output logic                             avmm_read,
  output logic                             avmm_write,
  output logic [`XCVR_ADDR_BITS-1:0]       avmm_address,
  output logic [`XCVR_DATA_BITS-1:0]       avmm_writedata,
  input  wire logic [`XCVR_DATA_BITS-1:0]  avmm_readdata,
  input  wire logic                        avmm_waitrequest
);

  logic       csr_hit;
  logic       csr_read;
  logic       csr_write;
  chan_rsp_t  csr_rsp;
  chan_rsp_t  xcvr_rsp;

  assign csr_hit = chan_req.addr.xcvr.csr_sel;

  // CSR side
  assign csr_read  = chan_req.read  &  csr_hit;
  assign csr_write = chan_req.write &  csr_hit;

  // Transceiver side never sees a CSR access
  assign avmm_read      = chan_req.read  & ~csr_hit;
  assign avmm_write     = chan_req.write & ~csr_hit;
  assign avmm_address   = chan_req.addr.xcvr.offset;
  assign avmm_writedata = chan_req.writedata;

  assign xcvr_rsp.readdata    = avmm_readdata;
  assign xcvr_rsp.waitrequest = avmm_waitrequest;

  // Transceiver waitrequest passes straight through to the host
  assign chan_rsp = csr_hit ? csr_rsp : xcvr_rsp;

  pll_soft_csr u_soft_csr (
    .reconfig_clk   (reconfig_clk),
    .rst_n          (rst_n),
    .csr_read       (csr_read),
    .csr_write      (csr_write),
    .csr_index      (chan_req.addr.csr.index),
    .csr_writedata  (chan_req.writedata),
    .csr_rsp        (csr_rsp),
    .status         (status),
    .pll_powerdown  (pll_powerdown)
  );

endmodule

`default_nettype wire

// File: logic/rcfg_return_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Returns the addressed channel's response to the
// host, readdata zero-extended to the bus width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "pll_rcfg_macros.svh"

module rcfg_return_mux
  import pll_rcfg_pkg::*;
(
  input  chan_sel_t                          chan_sel,
  input  chan_rsp_t [`NUM_CHANNELS-1:0]      chan_rsp,
  output logic [`BUS_DATA_BITS-1:0]          reconfig_readdata,
  output logic                               reconfig_waitrequest
);

  chan_rsp_t  sel_rsp;

  // Index comes decoded from the splitter
  assign sel_rsp = chan_rsp[chan_sel];

  // Upper bits are always zero on the host bus
  assign reconfig_readdata = {
    {(`BUS_DATA_BITS-`XCVR_DATA_BITS){1'b0}},
    sel_rsp.readdata
  };

  assign reconfig_waitrequest = sel_rsp.waitrequest;

endmodule

`default_nettype wire

// File: logic/pll_rcfg_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the PLL reconfiguration front end: one
// shared host bus in, one transceiver port and one
// powerdown output per channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "pll_rcfg_macros.svh"

module pll_rcfg_top
  import pll_rcfg_pkg::*;
(
  input  wire logic                                            reconfig_clk,
  input  wire logic                                            rst_n,

  // Shared host bus
  input  wire logic                                            reconfig_read,
  input  wire logic                                            reconfig_write,
  input  wire logic [`HOST_ADDR_BITS-1:0]                      reconfig_address,
  input  wire logic [`BUS_DATA_BITS-1:0]                       reconfig_writedata,
  output logic [`BUS_DATA_BITS-1:0]                            reconfig_readdata,
  output logic                                                 reconfig_waitrequest,

  // Transceiver ports, one per channel
  output logic [`NUM_CHANNELS-1:0]                             avmm_read,
  output logic [`NUM_CHANNELS-1:0]                             avmm_write,
  output logic [`NUM_CHANNELS-1:0][`XCVR_ADDR_BITS-1:0]        avmm_address,
  output logic [`NUM_CHANNELS-1:0][`XCVR_DATA_BITS-1:0]        avmm_writedata,
  input  wire logic [`NUM_CHANNELS-1:0][`XCVR_DATA_BITS-1:0]   avmm_readdata,
  input  wire logic [`NUM_CHANNELS-1:0]                        avmm_waitrequest,

  // PLL status and powerdown
  input  pll_status_t [`NUM_CHANNELS-1:0]                      pll_status,
  output logic [`NUM_CHANNELS-1:0]                             pll_powerdown
);

  host_req_t                         host_req;
  chan_req_t [`NUM_CHANNELS-1:0]     chan_req;
  chan_rsp_t [`NUM_CHANNELS-1:0]     chan_rsp;
  chan_sel_t                         chan_sel;

  assign host_req = '{
    read:      reconfig_read,
    write:     reconfig_write,
    address:   reconfig_address,
    writedata: reconfig_writedata
  };

  rcfg_splitter u_splitter (
    .host_req  (host_req),
    .chan_req  (chan_req),
    .chan_sel  (chan_sel)
  );

  for (genvar ch = 0; ch < `NUM_CHANNELS; ch++) begin : g_chan
    chan_router u_router (
      .reconfig_clk      (reconfig_clk),
      .rst_n             (rst_n),
      .chan_req          (chan_req[ch]),
      .chan_rsp          (chan_rsp[ch]),
      .status            (pll_status[ch]),
      .pll_powerdown     (pll_powerdown[ch]),
      .avmm_read         (avmm_read[ch]),
      .avmm_write        (avmm_write[ch]),
      .avmm_address      (avmm_address[ch]),
      .avmm_writedata    (avmm_writedata[ch]),
      .avmm_readdata     (avmm_readdata[ch]),
      .avmm_waitrequest  (avmm_waitrequest[ch])
    );
  end

  rcfg_return_mux u_return_mux (
    .chan_sel              (chan_sel),
    .chan_rsp              (chan_rsp),
    .reconfig_readdata     (reconfig_readdata),
    .reconfig_waitrequest  (reconfig_waitrequest)
  );

endmodule

`default_nettype wire

// File: test/tb_pll_rcfg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the PLL reconfiguration front end.
// Replays the transaction data file against the DUT
// with one behavioral transceiver model per channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "pll_rcfg_macros.svh"

module tb_pll_rcfg
  import pll_rcfg_pkg::*;
();

  localparam int NCH        = `NUM_CHANNELS;
  localparam int WAIT_LIMIT = 40;

  logic                                  reconfig_clk;
  logic                                  rst_n;
  logic                                  reconfig_read;
  logic                                  reconfig_write;
  logic [`HOST_ADDR_BITS-1:0]            reconfig_address;
  logic [`BUS_DATA_BITS-1:0]             reconfig_writedata;
  logic [`BUS_DATA_BITS-1:0]             reconfig_readdata;
  logic                                  reconfig_waitrequest;
  logic [NCH-1:0]                        avmm_read;
  logic [NCH-1:0]                        avmm_write;
  logic [NCH-1:0][`XCVR_ADDR_BITS-1:0]   avmm_address;
  logic [NCH-1:0][`XCVR_DATA_BITS-1:0]   avmm_writedata;
  logic [NCH-1:0][`XCVR_DATA_BITS-1:0]   avmm_readdata;
  logic [NCH-1:0]                        avmm_waitrequest;
  pll_status_t [NCH-1:0]                 pll_status;
  logic [NCH-1:0]                        pll_powerdown;

  // Transceiver model state
  logic [7:0]   xcvr_mem [NCH][512];
  logic [1:0]   wait_left [NCH];
  logic [31:0]  rng_state;

  int           errors;
  int           tests;
  bit           timed_out;

  pll_rcfg_top uut (
    .reconfig_clk          (reconfig_clk),
    .rst_n                 (rst_n),
    .reconfig_read         (reconfig_read),
    .reconfig_write        (reconfig_write),
    .reconfig_address      (reconfig_address),
    .reconfig_writedata    (reconfig_writedata),
    .reconfig_readdata     (reconfig_readdata),
    .reconfig_waitrequest  (reconfig_waitrequest),
    .avmm_read             (avmm_read),
    .avmm_write            (avmm_write),
    .avmm_address          (avmm_address),
    .avmm_writedata        (avmm_writedata),
    .avmm_readdata         (avmm_readdata),
    .avmm_waitrequest      (avmm_waitrequest),
    .pll_status            (pll_status),
    .pll_powerdown         (pll_powerdown)
  );

  initial begin
    reconfig_clk = 1'b0;
    forever #4 reconfig_clk = ~reconfig_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Read data follows the address like an asynchronous RAM
  for (genvar g = 0; g < NCH; g++) begin : g_rdata
    assign avmm_readdata[g] = xcvr_mem[g][avmm_address[g]];
  end

  // Each access waits 0 to 3 cycles drawn before it starts
  always @(posedge reconfig_clk) begin
    for (int c = 0; c < NCH; c++) begin
      if (!rst_n) begin
        rng_state = xorshift32(rng_state);
        wait_left[c] <= rng_state[1:0];
      end else if (avmm_read[c] || avmm_write[c]) begin
        if (wait_left[c] != 2'd0) begin
          wait_left[c] <= wait_left[c] - 2'd1;
        end else begin
          if (avmm_write[c]) begin
            xcvr_mem[c][avmm_address[c]] <= avmm_writedata[c];
          end
          rng_state = xorshift32(rng_state);
          wait_left[c] <= rng_state[1:0];
        end
      end
    end
  end

  always @(negedge reconfig_clk) begin
    for (int c = 0; c < NCH; c++) begin
      avmm_waitrequest[c] <= (wait_left[c] != 2'd0);
    end
  end

  task automatic flag_error(input string msg);
    $display("FAIL at %0d ns: %s", $time, msg);
    errors++;
  endtask

  // One host access held until waitrequest drops or the limit runs out
  task automatic bus_access(input bit is_wr, input int ch, input logic [8:0] off,
                            input bit csr, input logic [7:0] data,
                            output logic [31:0] rdata, output int edges, output bit ok);
    logic [NCH-1:0] exp_rd;
    logic [NCH-1:0] exp_wr;
    bit             done;
    bit             bad;
    exp_rd = '0;
    exp_wr = '0;
    if (!csr && is_wr) exp_wr[ch] = 1'b1;
    if (!csr && !is_wr) exp_rd[ch] = 1'b1;
    done  = 0;
    bad   = 0;
    edges = 0;
    rdata = '0;
    @(negedge reconfig_clk);
    reconfig_address   = {ch[1:0], csr, off};
    reconfig_writedata = {24'h3b7d11, data};
    reconfig_read      = !is_wr;
    reconfig_write     = is_wr;
    while (!done && edges < WAIT_LIMIT) begin
      @(posedge reconfig_clk);
      edges++;
      if (!bad && (avmm_read !== exp_rd || avmm_write !== exp_wr)) begin
        flag_error($sformatf("avmm strobes rd %b wr %b, expected rd %b wr %b",
                             avmm_read, avmm_write, exp_rd, exp_wr));
        bad = 1;
      end
      if (!bad && !csr && avmm_address[ch] !== off) begin
        flag_error($sformatf("avmm_address %h, expected %h", avmm_address[ch], off));
        bad = 1;
      end
      if (!bad && !csr && is_wr && avmm_writedata[ch] !== data) begin
        flag_error($sformatf("avmm_writedata %h, expected %h", avmm_writedata[ch], data));
        bad = 1;
      end
      // Transceiver back-pressure reaches the host unchanged
      if (!bad && !csr && reconfig_waitrequest !== avmm_waitrequest[ch]) begin
        flag_error($sformatf("reconfig_waitrequest %b, transceiver waitrequest %b",
                             reconfig_waitrequest, avmm_waitrequest[ch]));
        bad = 1;
      end
      if (!reconfig_waitrequest) begin
        done  = 1;
        rdata = reconfig_readdata;
      end
    end
    @(negedge reconfig_clk);
    reconfig_read  = 1'b0;
    reconfig_write = 1'b0;
    ok = done;
  endtask

  task automatic run_step(input logic [7:0] op, input int ch, input logic [8:0] off,
                          input bit csr, input logic [7:0] data, input logic [31:0] exp);
    logic [31:0] rdata;
    int          edges;
    bit          ok;
    int          err_before;
    err_before = errors;
    tests++;
    case (op)
      "S": begin
        @(negedge reconfig_clk);
        pll_status[ch] = pll_status_t'(data[3:0]);
        // Let the status register sample the new inputs
        repeat (2) @(posedge reconfig_clk);
        if (pll_powerdown !== exp[NCH-1:0]) begin
          flag_error($sformatf("pll_powerdown %b, expected %b", pll_powerdown, exp[NCH-1:0]));
        end
      end
      "W", "R": begin
        bus_access(op == "W", ch, off, csr, data, rdata, edges, ok);
        if (!ok) begin
          $display("Timeout: waitrequest stayed high for %0d cycles on channel %0d at %0d ns",
                   WAIT_LIMIT, ch, $time);
          errors++;
          timed_out = 1;
        end else begin
          if (csr && edges != 2) begin
            flag_error($sformatf("CSR access took %0d edges, expected 2", edges));
          end
          if (op == "R" && rdata !== exp) begin
            flag_error($sformatf("readdata %h, expected %h", rdata, exp));
          end
          if (op == "W" && pll_powerdown !== exp[NCH-1:0]) begin
            flag_error($sformatf("pll_powerdown %b, expected %b", pll_powerdown, exp[NCH-1:0]));
          end
        end
      end
      default: begin
        $display("Unknown operation '%c' in the data file", op);
        errors++;
      end
    endcase
    $display("test %0d: %c ch%0d off %h csr %0d %s", tests, op, ch, off, csr,
             (errors == err_before) ? "ok" : "mismatch");
  endtask

  initial begin
    int          fd;
    int          n;
    int          c;
    bit          eof;
    logic [7:0]  op;
    logic [31:0] f_ch;
    logic [31:0] f_off;
    logic [31:0] f_csr;
    logic [31:0] f_data;
    logic [31:0] f_exp;
    rst_n              = 1'b0;
    reconfig_read      = 1'b0;
    reconfig_write     = 1'b0;
    reconfig_address   = '0;
    reconfig_writedata = '0;
    avmm_waitrequest   = '1;
    // Channels 3 down to 0
    pll_status         = {4'h8, 4'h4, 4'h0, 4'hc};
    rng_state          = 32'd35870;
    errors             = 0;
    tests              = 0;
    timed_out          = 0;
    for (int ch = 0; ch < NCH; ch++) begin
      for (int a = 0; a < 512; a++) begin
        xcvr_mem[ch][a] = 8'(a) ^ 8'(a >> 1) ^ 8'(ch * 8'h47);
      end
    end

    repeat (10) @(posedge reconfig_clk);
    @(negedge reconfig_clk);
    rst_n = 1'b1;

    // After reset the override is off and the transceiver ports are idle
    tests++;
    for (int ch = 0; ch < NCH; ch++) begin
      if (pll_powerdown[ch] !== pll_status[ch].powerdown) begin
        flag_error($sformatf("ch%0d pll_powerdown does not follow its input", ch));
      end
    end
    if (avmm_read !== '0 || avmm_write !== '0) begin
      flag_error($sformatf("avmm strobes rd %b wr %b after reset", avmm_read, avmm_write));
    end
    $display("test %0d: after reset %s", tests, (errors == 0) ? "ok" : "mismatch");

    fd = $fopen("test/pll_rcfg_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the data file test/pll_rcfg_testdata.txt");
      errors++;
    end else begin
      eof = 0;
      while (!eof && !timed_out) begin
        n = $fscanf(fd, " %c", op);
        if (n != 1) begin
          eof = 1;
        end else if (op == "#") begin
          c = $fgetc(fd);
          while (c != "\n" && c != -1) c = $fgetc(fd);
        end else begin
          n = $fscanf(fd, "%h %h %h %h %h", f_ch, f_off, f_csr, f_data, f_exp);
          if (n != 5) begin
            $display("Malformed line in the data file after test %0d", tests);
            errors++;
            eof = 1;
          end else begin
            run_step(op, f_ch, f_off[8:0], f_csr[0], f_data[7:0], f_exp);
          end
        end
      end
      $fclose(fd);
    end

    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/pll_rcfg_testdata.txt
# op ch offset csr data expected, all hex after op; W write, R read, S set channel status
# expected: readdata for R, pll_powerdown vector of channels 3..0 for W and S
W 0 010 0 a5 9
W 1 010 0 3c 9
W 2 010 0 c3 9
W 3 010 0 5a 9
R 0 010 0 00 a5
R 1 010 0 00 3c
R 2 010 0 00 c3
R 3 010 0 00 5a
W 2 1ff 0 77 9
R 2 1ff 0 00 77
R 0 010 0 00 a5
S 1 000 0 0e b
R 1 000 1 00 0e
S 2 000 0 07 b
R 2 000 1 00 07
W 2 001 1 03 f
R 2 001 1 00 03
W 1 001 1 01 d
S 2 000 0 00 d
S 0 000 0 00 c
W 2 001 1 00 8
R 2 001 1 00 00
W 1 001 1 00 a
R 3 000 1 00 08
W 3 005 1 ff a
R 3 005 1 00 00
W 1 123 0 96 a
R 1 123 0 00 96

// File: tb.f
+incdir+logic
logic/pll_rcfg_pkg.sv
logic/rcfg_splitter.sv
logic/pll_soft_csr.sv
logic/chan_router.sv
logic/rcfg_return_mux.sv
logic/pll_rcfg_top.sv
test/tb_pll_rcfg.sv
